/* scanconv_defines.svh */
`ifndef SCANCONV_DEFINES_SVH
`define SCANCONV_DEFINES_SVH

// Width of one colour channel
`define SC_COLOR_W 8

// Horizontal counter and x-position width
`define SC_HCNT_W 12

// Vertical counter and y-position width
`define SC_VCNT_W 11

// Number of line phases the scanline generator can cycle through
`define SC_SL_PHASES 6

// Width of one per-phase scanline strength code
`define SC_SL_STR_W 4

// Register stages from the counters to the outputs, counting the
// stage-1 decode registers
`define SC_PIPE_DEPTH 4

`endif

/* scanconv_pkg.sv */
`include "scanconv_defines.svh"

package scanconv_pkg;

    typedef logic [`SC_COLOR_W-1:0] color_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    typedef logic [`SC_HCNT_W-1:0] hpos_t;
    typedef logic [`SC_VCNT_W-1:0] vpos_t;

    typedef logic [`SC_SL_STR_W-1:0] sl_str_t;

    // Active area starts at sync_len + backporch in both directions
    typedef struct packed {
        hpos_t total;
        hpos_t active;
        hpos_t sync_len;
        hpos_t backporch;
    } h_timing_t;

    typedef struct packed {
        vpos_t total;
        vpos_t active;
        vpos_t sync_len;
        vpos_t backporch;
    } v_timing_t;

endpackage

/* raster_if.sv */
interface raster_if;

    // All signals are stage-1 registers in the timing generator
    logic                hsync;
    logic                vsync;
    logic                de;
    scanconv_pkg::hpos_t xpos;
    scanconv_pkg::vpos_t ypos;
    logic                line_start;
    logic                frame_start;
    logic                active_line;

    modport source (
        output hsync, vsync, de, xpos, ypos, line_start, frame_start, active_line
    );

    modport sl_sink (
        input line_start, frame_start, active_line
    );

    modport mask_sink (
        input xpos, ypos
    );

    modport post_sink (
        input hsync, vsync, de, xpos, ypos
    );

endinterface

/* raster_timing.sv */
module raster_timing (
    input  logic                    PCLK_OUT_i,
    input  logic                    rst_n_i,
    input  logic                    ext_frame_start_i,
    input  scanconv_pkg::h_timing_t h_cfg_i,
    input  scanconv_pkg::v_timing_t v_cfg_i,
    raster_if.source                rif
);

    scanconv_pkg::hpos_t h_cnt;
    scanconv_pkg::vpos_t v_cnt;
    scanconv_pkg::hpos_t h_start;
    scanconv_pkg::vpos_t v_start;
    logic                h_in_active;
    logic                v_in_active;
    logic                line_start_slot;

    assign h_start = h_cfg_i.sync_len + h_cfg_i.backporch;
    assign v_start = v_cfg_i.sync_len + v_cfg_i.backporch;

    // Offset compare avoids overflow of start + active near the counter limit
    assign h_in_active = (h_cnt >= h_start) && ((h_cnt - h_start) < h_cfg_i.active);
    assign v_in_active = (v_cnt >= v_start) && ((v_cnt - v_start) < v_cfg_i.active);

    assign line_start_slot = (h_cnt == h_start);

    // External frame start overrides the normal wrap on the same edge
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (ext_frame_start_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_cfg_i.total - 1'b1) begin
            h_cnt <= '0;
            if (v_cnt == v_cfg_i.total - 1'b1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Stage 1 sync, enable and line markers
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rif.hsync       <= 1'b1;
            rif.vsync       <= 1'b1;
            rif.de          <= 1'b0;
            rif.line_start  <= 1'b0;
            rif.frame_start <= 1'b0;
            rif.active_line <= 1'b0;
        end else begin
            rif.hsync       <= (h_cnt >= h_cfg_i.sync_len);
            rif.vsync       <= (v_cnt >= v_cfg_i.sync_len);
            rif.de          <= h_in_active && v_in_active;
            rif.line_start  <= line_start_slot;
            rif.frame_start <= line_start_slot && (v_cnt == '0);
            rif.active_line <= v_in_active;
        end
    end

    // Positions are only meaningful while DE is high
    always_ff @(posedge PCLK_OUT_i) begin
        rif.xpos <= h_cnt - h_start;
        rif.ypos <= v_cnt - v_start;
    end

endmodule

/* scanline_gen.sv */
`include "scanconv_defines.svh"

module scanline_gen (
    input  logic                                          PCLK_OUT_i,
    input  logic                                          rst_n_i,
    raster_if.sl_sink                                     rif,
    input  logic                                          sl_enable_i,
    input  logic [`SC_SL_PHASES-1:0]                      sl_overlay_i,
    input  scanconv_pkg::sl_str_t [`SC_SL_PHASES-1:0]     sl_str_i,
    input  logic [2:0]                                    sl_period_i,
    input  logic                                          sl_mult_i,
    output logic                                          sl_draw_o,
    output scanconv_pkg::color_t                          sl_level_o,
    output logic                                          sl_is_mult_o
);

    logic [2:0] phase_q;
    logic [2:0] phase_d;
    logic [2:0] str_sel;
    logic       phase_hit;

    // The pixel carrying line_start already sees the stepped phase
    always_comb begin
        phase_d = phase_q;
        if (rif.frame_start) begin
            phase_d = '0;
        end else if (rif.line_start && rif.active_line) begin
            if (phase_q >= sl_period_i) begin
                phase_d = '0;
            end else begin
                phase_d = phase_q + 3'd1;
            end
        end
    end

    // Phases beyond the last overlay bit shift out and never draw
    assign phase_hit = |(sl_overlay_i & (`SC_SL_PHASES'(1) << phase_d));
    assign str_sel   = (phase_d < `SC_SL_PHASES) ? phase_d : '0;

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q      <= '0;
            sl_draw_o    <= 1'b0;
            sl_level_o   <= '0;
            sl_is_mult_o <= 1'b0;
        end else begin
            phase_q      <= phase_d;
            sl_draw_o    <= sl_enable_i && phase_hit;
            // Level is (code + 1) * 16 - 1, i.e. the code with an all-ones low nibble
            sl_level_o   <= {sl_str_i[str_sel], {(`SC_COLOR_W-`SC_SL_STR_W){1'b1}}};
            sl_is_mult_o <= sl_mult_i;
        end
    end

endmodule

/* window_mask.sv */
`include "scanconv_defines.svh"

module window_mask (
    input  logic                 PCLK_OUT_i,
    input  logic                 rst_n_i,
    raster_if.mask_sink          rif,
    input  scanconv_pkg::hpos_t  win_x_start_i,
    input  scanconv_pkg::hpos_t  win_x_size_i,
    input  scanconv_pkg::vpos_t  win_y_start_i,
    input  scanconv_pkg::vpos_t  win_y_size_i,
    input  logic [3:0]           mask_bright_i,
    input  logic [2:0]           mask_color_i,
    input  logic                 testpattern_i,
    output logic                 ovr_o,
    output scanconv_pkg::rgb_t   ovr_rgb_o
);

    logic                 in_win_x;
    logic                 in_win_y;
    scanconv_pkg::color_t tp_val;
    scanconv_pkg::color_t mask_val;

    // Half-open window [start, start + size)
    assign in_win_x = (rif.xpos >= win_x_start_i) && ((rif.xpos - win_x_start_i) < win_x_size_i);
    assign in_win_y = (rif.ypos >= win_y_start_i) && ((rif.ypos - win_y_start_i) < win_y_size_i);

    assign tp_val   = rif.xpos[`SC_COLOR_W-1:0] ^ rif.ypos[`SC_COLOR_W-1:0];
    assign mask_val = {2{mask_bright_i}};

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ovr_o <= 1'b0;
        end else begin
            ovr_o <= testpattern_i || !(in_win_x && in_win_y);
        end
    end

    // Colour bits are red, green, blue from MSB down
    always_ff @(posedge PCLK_OUT_i) begin
        if (testpattern_i) begin
            ovr_rgb_o.r <= tp_val;
            ovr_rgb_o.g <= tp_val;
            ovr_rgb_o.b <= tp_val;
        end else begin
            ovr_rgb_o.r <= mask_color_i[2] ? mask_val : '0;
            ovr_rgb_o.g <= mask_color_i[1] ? mask_val : '0;
            ovr_rgb_o.b <= mask_color_i[0] ? mask_val : '0;
        end
    end

endmodule

/* pixel_post.sv */
`include "scanconv_defines.svh"

module pixel_post (
    input  logic                 PCLK_OUT_i,
    input  logic                 rst_n_i,
    raster_if.post_sink          rif,
    input  scanconv_pkg::rgb_t   ext_rgb_i,
    input  logic                 sl_draw_i,
    input  scanconv_pkg::color_t sl_level_i,
    input  logic                 sl_is_mult_i,
    input  logic                 ovr_i,
    input  scanconv_pkg::rgb_t   ovr_rgb_i,
    output scanconv_pkg::rgb_t   rgb_o,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 de_o,
    output scanconv_pkg::hpos_t  xpos_o,
    output scanconv_pkg::vpos_t  ypos_o
);

    // Stage-1 raster values need this many more registers to reach stage 4
    localparam int DLY = `SC_PIPE_DEPTH - 1;

    logic [DLY-1:0]      hs_q;
    logic [DLY-1:0]      vs_q;
    logic [DLY-1:0]      de_q;
    scanconv_pkg::hpos_t xpos_q [DLY];
    scanconv_pkg::vpos_t ypos_q [DLY];

    scanconv_pkg::rgb_t  pix_s2;
    scanconv_pkg::rgb_t  pix_s3;
    scanconv_pkg::rgb_t  sub_s3;
    scanconv_pkg::rgb_t  mul_s3;
    scanconv_pkg::rgb_t  ovr_rgb_s3;
    logic                draw_s3;
    logic                mult_s3;
    logic                ovr_s3;

    function automatic scanconv_pkg::color_t sub_floor(input scanconv_pkg::color_t c,
                                                       input scanconv_pkg::color_t lvl);
        return (c > lvl) ? c - lvl : '0;
    endfunction

    // High byte of c * (255 - lvl)
    function automatic scanconv_pkg::color_t mul_hi(input scanconv_pkg::color_t c,
                                                    input scanconv_pkg::color_t lvl);
        scanconv_pkg::color_t     inv;
        logic [2*`SC_COLOR_W-1:0] prod;
        inv  = ~lvl;
        prod = c * inv;
        return prod[2*`SC_COLOR_W-1:`SC_COLOR_W];
    endfunction

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hs_q <= '1;
            vs_q <= '1;
            de_q <= '0;
        end else begin
            hs_q <= {hs_q[DLY-2:0], rif.hsync};
            vs_q <= {vs_q[DLY-2:0], rif.vsync};
            de_q <= {de_q[DLY-2:0], rif.de};
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        xpos_q[0] <= rif.xpos;
        ypos_q[0] <= rif.ypos;
        for (int i = 1; i < DLY; i++) begin
            xpos_q[i] <= xpos_q[i-1];
            ypos_q[i] <= ypos_q[i-1];
        end
    end

    // Stage 2 capture and stage 3 darkening, both methods in parallel
    always_ff @(posedge PCLK_OUT_i) begin
        pix_s2     <= ext_rgb_i;
        pix_s3     <= pix_s2;
        sub_s3.r   <= sub_floor(pix_s2.r, sl_level_i);
        sub_s3.g   <= sub_floor(pix_s2.g, sl_level_i);
        sub_s3.b   <= sub_floor(pix_s2.b, sl_level_i);
        mul_s3.r   <= mul_hi(pix_s2.r, sl_level_i);
        mul_s3.g   <= mul_hi(pix_s2.g, sl_level_i);
        mul_s3.b   <= mul_hi(pix_s2.b, sl_level_i);
        ovr_rgb_s3 <= ovr_rgb_i;
    end

    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            draw_s3 <= 1'b0;
            mult_s3 <= 1'b0;
            ovr_s3  <= 1'b0;
        end else begin
            draw_s3 <= sl_draw_i;
            mult_s3 <= sl_is_mult_i;
            ovr_s3  <= ovr_i;
        end
    end

    // Stage 4 output select. Override wins over scanlines
    always_ff @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rgb_o <= '0;
        end else if (ovr_s3) begin
            rgb_o <= ovr_rgb_s3;
        end else if (draw_s3) begin
            rgb_o <= mult_s3 ? mul_s3 : sub_s3;
        end else begin
            rgb_o <= pix_s3;
        end
    end

    assign hsync_o = hs_q[DLY-1];
    assign vsync_o = vs_q[DLY-1];
    assign de_o    = de_q[DLY-1];
    assign xpos_o  = xpos_q[DLY-1];
    assign ypos_o  = ypos_q[DLY-1];

endmodule

/* scanconv_top.sv */
`include "scanconv_defines.svh"

module scanconv_top (
    input  logic                                  PCLK_OUT_i,
    input  logic                                  rst_n_i,
    input  logic                                  ext_frame_start_i,
    input  logic [`SC_COLOR_W-1:0]                ext_r_i,
    input  logic [`SC_COLOR_W-1:0]                ext_g_i,
    input  logic [`SC_COLOR_W-1:0]                ext_b_i,
    input  logic [`SC_HCNT_W-1:0]                 h_total_i,
    input  logic [`SC_HCNT_W-1:0]                 h_active_i,
    input  logic [`SC_HCNT_W-1:0]                 h_synclen_i,
    input  logic [`SC_HCNT_W-1:0]                 h_backporch_i,
    input  logic [`SC_VCNT_W-1:0]                 v_total_i,
    input  logic [`SC_VCNT_W-1:0]                 v_active_i,
    input  logic [`SC_VCNT_W-1:0]                 v_synclen_i,
    input  logic [`SC_VCNT_W-1:0]                 v_backporch_i,
    input  logic [`SC_HCNT_W-1:0]                 win_x_start_i,
    input  logic [`SC_HCNT_W-1:0]                 win_x_size_i,
    input  logic [`SC_VCNT_W-1:0]                 win_y_start_i,
    input  logic [`SC_VCNT_W-1:0]                 win_y_size_i,
    input  logic [3:0]                            mask_bright_i,
    input  logic [2:0]                            mask_color_i,
    input  logic                                  testpattern_i,
    input  logic                                  sl_enable_i,
    input  logic [`SC_SL_PHASES-1:0]              sl_overlay_i,
    input  logic [`SC_SL_PHASES*`SC_SL_STR_W-1:0] sl_str_i,
    input  logic [2:0]                            sl_period_i,
    input  logic                                  sl_mult_i,
    output logic [`SC_COLOR_W-1:0]                r_o,
    output logic [`SC_COLOR_W-1:0]                g_o,
    output logic [`SC_COLOR_W-1:0]                b_o,
    output logic                                  hsync_o,
    output logic                                  vsync_o,
    output logic                                  de_o,
    output logic [`SC_HCNT_W-1:0]                 xpos_o,
    output logic [`SC_VCNT_W-1:0]                 ypos_o
);

    scanconv_pkg::h_timing_t h_cfg;
    scanconv_pkg::v_timing_t v_cfg;
    scanconv_pkg::rgb_t      ext_rgb;
    scanconv_pkg::rgb_t      rgb_out;
    scanconv_pkg::rgb_t      ovr_rgb;
    scanconv_pkg::color_t    sl_level;
    logic                    sl_draw;
    logic                    sl_is_mult;
    logic                    ovr;

    assign h_cfg.total     = h_total_i;
    assign h_cfg.active    = h_active_i;
    assign h_cfg.sync_len  = h_synclen_i;
    assign h_cfg.backporch = h_backporch_i;
    assign v_cfg.total     = v_total_i;
    assign v_cfg.active    = v_active_i;
    assign v_cfg.sync_len  = v_synclen_i;
    assign v_cfg.backporch = v_backporch_i;

    assign ext_rgb.r = ext_r_i;
    assign ext_rgb.g = ext_g_i;
    assign ext_rgb.b = ext_b_i;

    raster_if u_rif ();

    raster_timing u_raster_timing (
        .PCLK_OUT_i        (PCLK_OUT_i),
        .rst_n_i           (rst_n_i),
        .ext_frame_start_i (ext_frame_start_i),
        .h_cfg_i           (h_cfg),
        .v_cfg_i           (v_cfg),
        .rif               (u_rif.source)
    );

    scanline_gen u_scanline_gen (
        .PCLK_OUT_i   (PCLK_OUT_i),
        .rst_n_i      (rst_n_i),
        .rif          (u_rif.sl_sink),
        .sl_enable_i  (sl_enable_i),
        .sl_overlay_i (sl_overlay_i),
        .sl_str_i     (sl_str_i),
        .sl_period_i  (sl_period_i),
        .sl_mult_i    (sl_mult_i),
        .sl_draw_o    (sl_draw),
        .sl_level_o   (sl_level),
        .sl_is_mult_o (sl_is_mult)
    );

    window_mask u_window_mask (
        .PCLK_OUT_i    (PCLK_OUT_i),
        .rst_n_i       (rst_n_i),
        .rif           (u_rif.mask_sink),
        .win_x_start_i (win_x_start_i),
        .win_x_size_i  (win_x_size_i),
        .win_y_start_i (win_y_start_i),
        .win_y_size_i  (win_y_size_i),
        .mask_bright_i (mask_bright_i),
        .mask_color_i  (mask_color_i),
        .testpattern_i (testpattern_i),
        .ovr_o         (ovr),
        .ovr_rgb_o     (ovr_rgb)
    );

    pixel_post u_pixel_post (
        .PCLK_OUT_i   (PCLK_OUT_i),
        .rst_n_i      (rst_n_i),
        .rif          (u_rif.post_sink),
        .ext_rgb_i    (ext_rgb),
        .sl_draw_i    (sl_draw),
        .sl_level_i   (sl_level),
        .sl_is_mult_i (sl_is_mult),
        .ovr_i        (ovr),
        .ovr_rgb_i    (ovr_rgb),
        .rgb_o        (rgb_out),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .de_o         (de_o),
        .xpos_o       (xpos_o),
        .ypos_o       (ypos_o)
    );

    assign r_o = rgb_out.r;
    assign g_o = rgb_out.g;
    assign b_o = rgb_out.b;

endmodule

/* scanconv_asserts.sv */
`include "scanconv_defines.svh"

module scanconv_asserts (
    input logic                   PCLK_OUT_i,
    input logic                   rst_n_i,
    input logic                   hsync_o,
    input logic                   vsync_o,
    input logic                   de_o,
    input logic [`SC_HCNT_W-1:0]  xpos_o,
    input logic [`SC_HCNT_W-1:0]  h_active_i,
    input logic [`SC_COLOR_W-1:0] r_o,
    input logic [`SC_COLOR_W-1:0] g_o,
    input logic [`SC_COLOR_W-1:0] b_o
);

    // The active area always starts after the sync pulse
    de_outside_hsync: assert property (
        @(posedge PCLK_OUT_i) disable iff (!rst_n_i) de_o |-> hsync_o
    ) else $error("de_o high while hsync_o is low");

    de_xpos_range: assert property (
        @(posedge PCLK_OUT_i) disable iff (!rst_n_i) de_o |-> (xpos_o < h_active_i)
    ) else $error("xpos_o beyond the active width while de_o is high");

    reset_values: assert property (
        @(posedge PCLK_OUT_i) !rst_n_i |->
            (hsync_o && vsync_o && !de_o && r_o == '0 && g_o == '0 && b_o == '0)
    ) else $error("outputs not at reset values during reset");

endmodule

bind scanconv_top scanconv_asserts u_scanconv_asserts (.*);

/* tb_scanconv.sv */
`include "scanconv_defines.svh"

module tb_scanconv;

    localparam int NUM_FRAMES = 12;
    localparam int DE_TIMEOUT = 400;

    typedef struct packed {
        logic        hs;
        logic        vs;
        logic        de;
        logic        ls;
        logic        fs;
        logic        al;
        logic [11:0] x;
        logic [10:0] y;
    } dec_t;

    typedef struct packed {
        logic        ovr;
        logic [23:0] orgb;
        logic        draw;
        logic [7:0]  lvl;
        logic        mult;
        logic [23:0] pix;
    } st2_t;

    logic        PCLK_OUT_i;
    logic        rst_n_i;
    logic        ext_frame_start_i;
    logic [7:0]  ext_r_i;
    logic [7:0]  ext_g_i;
    logic [7:0]  ext_b_i;
    logic [11:0] h_total_i;
    logic [11:0] h_active_i;
    logic [11:0] h_synclen_i;
    logic [11:0] h_backporch_i;
    logic [10:0] v_total_i;
    logic [10:0] v_active_i;
    logic [10:0] v_synclen_i;
    logic [10:0] v_backporch_i;
    logic [11:0] win_x_start_i;
    logic [11:0] win_x_size_i;
    logic [10:0] win_y_start_i;
    logic [10:0] win_y_size_i;
    logic [3:0]  mask_bright_i;
    logic [2:0]  mask_color_i;
    logic        testpattern_i;
    logic        sl_enable_i;
    logic [5:0]  sl_overlay_i;
    logic [23:0] sl_str_i;
    logic [2:0]  sl_period_i;
    logic        sl_mult_i;
    logic [7:0]  r_o;
    logic [7:0]  g_o;
    logic [7:0]  b_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        de_o;
    logic [11:0] xpos_o;
    logic [10:0] ypos_o;

    logic [31:0] rng;
    logic [11:0] m_h;
    logic [10:0] m_v;
    logic [2:0]  m_phase;
    int          m_valid;
    dec_t        d_hist [4];
    st2_t        s_hist [3];
    dec_t        cur_dec;
    st2_t        cur_s2;
    int          errs [3];
    int          timeouts;
    logic        timed_out;

    scanconv_top u_scanconv_top (.*);

    initial PCLK_OUT_i = 1'b0;
    always #5 PCLK_OUT_i = ~PCLK_OUT_i;

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Raster decode of one counter position with the current timing inputs
    function dec_t decode(input logic [11:0] h, input logic [10:0] v);
        logic [11:0] hs0;
        logic [10:0] vs0;
        logic        hin;
        logic        vin;
        dec_t        d;
        hs0  = h_synclen_i + h_backporch_i;
        vs0  = v_synclen_i + v_backporch_i;
        hin  = (h >= hs0) && ((h - hs0) < h_active_i);
        vin  = (v >= vs0) && ((v - vs0) < v_active_i);
        d.hs = (h >= h_synclen_i);
        d.vs = (v >= v_synclen_i);
        d.de = hin && vin;
        d.ls = (h == hs0);
        d.fs = d.ls && (v == 11'd0);
        d.al = vin;
        d.x  = h - hs0;
        d.y  = v - vs0;
        return d;
    endfunction

    function st2_t stage2(input dec_t d);
        logic       inx;
        logic       iny;
        logic [7:0] tp;
        logic [7:0] mv;
        logic [2:0] idx;
        logic [3:0] code;
        st2_t       s;
        inx    = (d.x >= win_x_start_i) && ((d.x - win_x_start_i) < win_x_size_i);
        iny    = (d.y >= win_y_start_i) && ((d.y - win_y_start_i) < win_y_size_i);
        tp     = d.x[7:0] ^ d.y[7:0];
        mv     = {mask_bright_i, mask_bright_i};
        s.ovr  = testpattern_i || !(inx && iny);
        if (testpattern_i) begin
            s.orgb = {tp, tp, tp};
        end else begin
            s.orgb = {mask_color_i[2] ? mv : 8'h00, mask_color_i[1] ? mv : 8'h00,
                      mask_color_i[0] ? mv : 8'h00};
        end
        idx    = (m_phase < 3'd6) ? m_phase : 3'd0;
        code   = sl_str_i[idx*4 +: 4];
        s.draw = sl_enable_i && (m_phase < 3'd6) && sl_overlay_i[idx];
        s.lvl  = 8'((32'(code) + 1) * 16 - 1);
        s.mult = sl_mult_i;
        s.pix  = {ext_r_i, ext_g_i, ext_b_i};
        return s;
    endfunction

    function logic [7:0] darken(input logic [7:0] c, input st2_t s);
        logic [15:0] p;
        p = 16'(c) * 16'(8'd255 - s.lvl);
        if (!s.draw) begin
            return c;
        end else if (s.mult) begin
            return p[15:8];
        end
        return (c > s.lvl) ? c - s.lvl : 8'd0;
    endfunction

    function logic [23:0] expected_rgb(input st2_t s);
        if (s.ovr) begin
            return s.orgb;
        end
        return {darken(s.pix[23:16], s), darken(s.pix[15:8], s), darken(s.pix[7:0], s)};
    endfunction

    // Reference model, stepped on the same edges as the DUT
    always @(posedge PCLK_OUT_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_h     = '0;
            m_v     = '0;
            m_phase = '0;
            m_valid = 0;
            for (int i = 0; i < 4; i++) begin
                d_hist[i] = '0;
            end
        end else begin
            cur_dec = decode(m_h, m_v);
            if (d_hist[0].fs) begin
                m_phase = 3'd0;
            end else if (d_hist[0].ls && d_hist[0].al) begin
                m_phase = (m_phase >= sl_period_i) ? 3'd0 : m_phase + 3'd1;
            end
            cur_s2    = stage2(d_hist[0]);
            d_hist[3] = d_hist[2];
            d_hist[2] = d_hist[1];
            d_hist[1] = d_hist[0];
            d_hist[0] = cur_dec;
            s_hist[2] = s_hist[1];
            s_hist[1] = s_hist[0];
            s_hist[0] = cur_s2;
            if (ext_frame_start_i) begin
                m_h = '0;
                m_v = '0;
            end else if (m_h == h_total_i - 12'd1) begin
                m_h = '0;
                m_v = (m_v == v_total_i - 11'd1) ? 11'd0 : m_v + 11'd1;
            end else begin
                m_h = m_h + 12'd1;
            end
            if (m_valid < 8) begin
                m_valid++;
            end
        end
    end

    task compare_field(input string name, input logic [31:0] got, input logic [31:0] exp,
                       input int cat);
        assert (got === exp) else begin
            errs[cat]++;
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task check_outputs();
        dec_t        d;
        st2_t        s;
        logic [23:0] e;
        d = d_hist[3];
        s = s_hist[2];
        e = expected_rgb(s);
        compare_field("hsync_o", 32'(hsync_o), 32'(d.hs), 0);
        compare_field("vsync_o", 32'(vsync_o), 32'(d.vs), 0);
        compare_field("de_o", 32'(de_o), 32'(d.de), 0);
        if (d.de) begin
            compare_field("xpos_o", 32'(xpos_o), 32'(d.x), 1);
            compare_field("ypos_o", 32'(ypos_o), 32'(d.y), 1);
        end
        compare_field("r_o", 32'(r_o), 32'(e[23:16]), 2);
        compare_field("g_o", 32'(g_o), 32'(e[15:8]), 2);
        compare_field("b_o", 32'(b_o), 32'(e[7:0]), 2);
    endtask

    // Outputs are compared in mid-cycle, away from the driving edge
    always @(negedge PCLK_OUT_i) begin
        if (rst_n_i && m_valid >= 4) begin
            check_outputs();
        end
    end

    task drive_pixel();
        ext_r_i = 8'(next_rand());
        ext_g_i = 8'(next_rand());
        ext_b_i = 8'(next_rand());
    endtask

    task step();
        @(posedge PCLK_OUT_i);
        #1;
        drive_pixel();
    endtask

    // Mode 0 subtractive, 1 multiplicative, 2 border mask, 3 test pattern
    // Scanlines are switched off in the last four frames
    task draw_config(input int f);
        int          mode;
        logic [31:0] r;
        mode          = f % 4;
        h_total_i     = 12'(36 + next_rand() % 9);
        h_synclen_i   = 12'(2 + next_rand() % 3);
        h_backporch_i = 12'(2 + next_rand() % 4);
        h_active_i    = h_total_i - h_synclen_i - h_backporch_i - 12'(2 + next_rand() % 4);
        v_total_i     = 11'(10 + next_rand() % 4);
        v_synclen_i   = 11'(1 + next_rand() % 2);
        v_backporch_i = 11'(1 + next_rand() % 2);
        // The last line stays blank so a restart never cuts an active line
        v_active_i    = v_total_i - v_synclen_i - v_backporch_i - 11'd1;
        if (mode < 2) begin
            win_x_start_i = '0;
            win_x_size_i  = h_active_i;
            win_y_start_i = '0;
            win_y_size_i  = v_active_i;
        end else begin
            win_x_start_i = 12'(next_rand() % 32'(h_active_i / 2));
            win_x_size_i  = 12'(1 + next_rand() % 32'(h_active_i));
            win_y_start_i = 11'(next_rand() % 32'(v_active_i / 2));
            win_y_size_i  = 11'(1 + next_rand() % 32'(v_active_i));
        end
        r             = next_rand();
        testpattern_i = (mode == 3);
        sl_mult_i     = (mode == 1) || (mode == 2 && r[0]);
        sl_enable_i   = (f < NUM_FRAMES - 4);
        sl_overlay_i  = 6'(next_rand());
        sl_str_i      = 24'(next_rand());
        sl_period_i   = 3'(next_rand());
        mask_bright_i = 4'(next_rand());
        mask_color_i  = 3'(next_rand());
    endtask

    // One restart followed by two whole frames
    task run_frame(input int f);
        int cycles;
        int n;
        draw_config(f);
        cycles            = 2 * int'(h_total_i) * int'(v_total_i);
        ext_frame_start_i = 1'b1;
        step();
        ext_frame_start_i = 1'b0;
        n = 1;
        while (!de_o && n < DE_TIMEOUT) begin
            step();
            n++;
        end
        if (!de_o) begin
            $display("timeout: de_o never went high after frame restart %0d", f);
            timeouts++;
            timed_out = 1'b1;
        end else begin
            while (n < cycles) begin
                step();
                n++;
            end
        end
    endtask

    initial begin
        rng               = 32'd73194;
        errs[0]           = 0;
        errs[1]           = 0;
        errs[2]           = 0;
        timeouts          = 0;
        timed_out         = 1'b0;
        rst_n_i           = 1'b1;
        ext_frame_start_i = 1'b0;
        draw_config(0);
        drive_pixel();
        #1;
        rst_n_i = 1'b0;
        repeat (16) @(posedge PCLK_OUT_i);
        #1;
        rst_n_i = 1'b1;
        for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
            run_frame(f);
        end
        $display("sync errors %0d, position errors %0d, pixel errors %0d, timeouts %0d",
                 errs[0], errs[1], errs[2], timeouts);
        if (errs[0] + errs[1] + errs[2] + timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
scanconv_pkg.sv
raster_if.sv
raster_timing.sv
scanline_gen.sv
window_mask.sv
pixel_post.sv
scanconv_top.sv
scanconv_asserts.sv
tb_scanconv.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scanconv
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) scanconv_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
